//--- run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of the softmax testbench

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --timescale 1ns/100ps -f sources.f \
  --top-module softmax_tb -o softmax_sim \
  && ./obj_dir/softmax_sim > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"

grep -q "Test failures found" "$LOG" \
  && { echo "Simulation reported failures"; exit 1; } \
  || { echo "Simulation finished without failures"; exit 0; }

//--- sim/softmax_clock_gen.sv
// Testbench clock and reset

`timescale 1ns/100ps
`default_nettype none

module softmax_clock_gen (
  output logic CLK,
  output logic RST
);

  // 8 ns period
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Reset held over the first 4 rising edges
  initial begin
    RST = 1'b1;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/softmax_tb.sv
// Softmax engine testbench

`timescale 1ns/100ps
`default_nettype none

module softmax_tb;

  import softmax_pkg::*;

  localparam int WAIT_LIMIT = 2000;
  localparam int ROW_W = MAX_LENGTH * X_W;

  logic CLK;
  logic RST;
  logic start;
  softmax_cfg_t cfg;
  logic in_vector_enable;
  logic in_scalar_enable;
  logic [X_W-1:0] data_in;
  logic ready;
  softmax_out_t result;

  integer seed;
  int error_count;
  int test_count;
  int failed_tests;
  // Expected quotients in output order
  logic [DATA_W-1:0] expected_q[$];
  // Job shape and pulse counts shared with the monitor
  int job_size;
  int job_len;
  int mon_elem;
  int mon_row;
  int scalar_count;
  int vector_count;
  int ready_count;

  softmax_clock_gen u_clock_gen (.CLK(CLK), .RST(RST));

  softmax_top DUT (
    .CLK(CLK), .RST(RST), .start(start), .cfg(cfg),
    .in_vector_enable(in_vector_enable), .in_scalar_enable(in_scalar_enable),
    .data_in(data_in), .ready(ready), .result(result)
  );

  //////////////////////////////////////////////////
  // Reference model and checking
  //////////////////////////////////////////////////

  // floor(2^(x_i + FRAC_W) / sum of 2^x_j)
  function automatic logic [DATA_W-1:0] ref_softmax(input logic [ROW_W-1:0] row,
                                                    input int len, input int idx);
    longint sum;
    longint num;
    sum = 0;
    for (int j = 0; j < len; j++) begin
      sum += longint'(1) << int'(row[j*X_W +: X_W]);
    end
    num = longint'(1) << (int'(row[idx*X_W +: X_W]) + FRAC_W);
    return DATA_W'(num / sum);
  endfunction

  task automatic check_value(input string what, input int got, input int exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic stop_on_timeout(input string what, input int limit);
    $display("Timeout after %0d cycles while waiting for %s", limit, what);
    $display("Test failures found");
    $finish;
  endtask

  // Outputs sampled on the falling edge
  always @(negedge CLK) begin : monitor
    int last_elem;
    int last_row;
    if (!RST) begin
      if (result.vector_enable) vector_count++;
      if (ready) ready_count++;
      if (result.scalar_enable) begin
        last_elem = int'(mon_elem == job_len - 1);
        last_row = int'(mon_row == job_size - 1);
        scalar_count++;
        check_value("expected value pending", int'(expected_q.size() != 0), 1);
        if (expected_q.size() != 0) begin
          check_value("result data", int'(result.data), int'(expected_q.pop_front()));
        end
        check_value("vector_enable at row end", int'(result.vector_enable), last_elem);
        check_value("ready on final output", int'(ready), last_elem & last_row);
        if (last_elem != 0) begin
          mon_elem = 0;
          mon_row++;
        end else begin
          mon_elem++;
        end
      end else begin
        check_value("vector_enable without output", int'(result.vector_enable), 0);
        check_value("ready without output", int'(ready), 0);
      end
    end
  end

  //////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////

  // One idle cycle, or random strobes while the engine divides
  task automatic drive_quiet(input bit junk);
    int r;
    r = $random(seed);
    @(posedge CLK);
    in_vector_enable <= junk & r[0];
    in_scalar_enable <= junk & r[1];
    data_in <= r[7:4];
  endtask

  // Mode 0 random, 1 all equal to value, otherwise a single 15 among zeros
  function automatic logic [ROW_W-1:0] make_row(input int mode, input int value,
                                                input int rix, input int len);
    logic [ROW_W-1:0] row;
    int r;
    row = '0;
    for (int i = 0; i < len; i++) begin
      r = $random(seed);
      case (mode)
        0: row[i*X_W +: X_W] = r[X_W-1:0];
        1: row[i*X_W +: X_W] = X_W'(value);
        default: row[i*X_W +: X_W] = (i == rix % len) ? 4'hf : 4'h0;
      endcase
    end
    return row;
  endfunction

  task automatic send_row(input logic [ROW_W-1:0] row, input int len, input bit gaps);
    int gap;
    for (int i = 0; i < len; i++) begin
      gap = gaps ? ($random(seed) & 3) : 0;
      repeat (gap) drive_quiet(1'b0);
      @(posedge CLK);
      // Vector strobe on the first element only
      in_vector_enable <= (i == 0);
      in_scalar_enable <= (i != 0);
      data_in <= row[i*X_W +: X_W];
    end
  endtask

  task automatic wait_row_end(input bit junk);
    int cycles;
    bit seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen) begin
      drive_quiet(junk);
      @(negedge CLK);
      seen = result.vector_enable;
      cycles++;
      if (!seen && cycles >= WAIT_LIMIT) stop_on_timeout("the row end strobe", WAIT_LIMIT);
    end
  endtask

  task automatic run_job(input int size, input int len, input int mode, input int value,
                         input bit gaps, input bit junk);
    logic [ROW_W-1:0] row;
    job_size = size;
    job_len = len;
    mon_elem = 0;
    mon_row = 0;
    scalar_count = 0;
    vector_count = 0;
    ready_count = 0;
    @(posedge CLK);
    cfg.size <= SIZE_W'(size);
    cfg.length <= LEN_W'(len);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
    for (int r = 0; r < size; r++) begin
      row = make_row(mode, value, r, len);
      for (int i = 0; i < len; i++) begin
        expected_q.push_back(ref_softmax(row, len, i));
      end
      send_row(row, len, gaps);
      wait_row_end(junk);
    end
    drive_quiet(1'b0);
    check_value("scalar_enable pulses per job", scalar_count, size * len);
    check_value("vector_enable pulses per job", vector_count, size);
    check_value("ready pulses per job", ready_count, 1);
    check_value("unused expected values", int'(expected_q.size()), 0);
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("Test %0d %s: PASS", test_count, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: FAIL", test_count, name);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main
    int errs;
    int cycles;
    seed = 32'h45bd;
    start = 1'b0;
    cfg = '0;
    in_vector_enable = 1'b0;
    in_scalar_enable = 1'b0;
    data_in = '0;
    error_count = 0;
    test_count = 0;
    failed_tests = 0;
    job_size = 1;
    job_len = 1;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
      if (RST && cycles >= 20) stop_on_timeout("reset release", 20);
    end while (RST);

    // Quiet outputs before any start
    errs = error_count;
    repeat (12) begin
      @(negedge CLK);
      check_value("ready after reset", int'(ready), 0);
      check_value("scalar_enable after reset", int'(result.scalar_enable), 0);
      check_value("vector_enable after reset", int'(result.vector_enable), 0);
    end
    report_test("reset state", errs);

    errs = error_count;
    run_job(2, 1, 1, 9, 1'b0, 1'b0);
    run_job(2, 3, 1, 7, 1'b0, 1'b0);
    run_job(1, 16, 1, 3, 1'b0, 1'b0);
    run_job(2, 5, 1, 0, 1'b0, 1'b0);
    report_test("uniform rows", errs);

    errs = error_count;
    repeat (5) begin
      run_job(1 + ($random(seed) & 3), 1 + ($random(seed) & 15), 0, 0, 1'b1, 1'b0);
    end
    report_test("random jobs with gaps", errs);

    // Single large term, then the widest possible sum
    errs = error_count;
    run_job(2, 16, 2, 0, 1'b0, 1'b0);
    run_job(1, 16, 1, 15, 1'b0, 1'b0);
    report_test("sum width extremes", errs);

    errs = error_count;
    run_job(5, 4, 0, 0, 1'b1, 1'b0);
    report_test("pulse counts", errs);

    errs = error_count;
    run_job(3, 6, 0, 0, 1'b1, 1'b1);
    run_job(2, 11, 0, 0, 1'b0, 1'b1);
    report_test("strobes while dividing and restart", errs);

    $display("Tests: %0d, failed tests: %0d, errors: %0d", test_count, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/softmax_ctrl_fsm.sv
// Softmax row controller

`timescale 1ns/100ps
`default_nettype none

module softmax_ctrl_fsm (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         start,
  input  wire                         in_vector_enable,
  input  wire                         in_scalar_enable,
  input  wire                         elem_last,
  input  wire                         row_last,
  input  wire                         div_done,
  input  wire [softmax_pkg::DATA_W-1:0] quotient,
  output logic                        counter_clear,
  output logic                        elem_inc,
  output logic                        row_inc,
  output logic                        accumulate,
  output logic                        clear_sum,
  output logic                        write_enable,
  output logic                        div_start,
  output logic                        ready,
  output softmax_pkg::softmax_out_t   result
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_COLLECT,
    ST_DIVIDE_START,
    ST_DIVIDE_WAIT,
    ST_EMIT
  } state_t;

  state_t state;

  // Set once the first element of a row is in
  logic row_open;
  logic accept;
  // Last quotient of the row is going out
  logic row_done;

  //////////////////////////////////////////////////
  // Strobes
  //////////////////////////////////////////////////

  // First element needs the vector strobe, the rest the scalar one
  assign accept = (state == ST_COLLECT) && (row_open ? in_scalar_enable : in_vector_enable);
  assign row_done = (state == ST_EMIT) && elem_last;

  assign counter_clear = (state == ST_IDLE) && start;
  // Index wraps to 0 after the last element
  assign elem_inc = accept || (state == ST_EMIT);
  assign row_inc = row_done && !row_last;
  // Buffer write and sum update share the edge
  assign accumulate = accept;
  assign write_enable = accept;
  // Fresh sum for a new job or the next row
  assign clear_sum = counter_clear || row_inc;
  assign div_start = (state == ST_DIVIDE_START);

  //////////////////////////////////////////////////
  // State and outputs
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ST_IDLE;
      row_open <= 1'b0;
      ready <= 1'b0;
      result <= '0;
    end else begin
      // Output strobes are single-cycle
      ready <= 1'b0;
      result.scalar_enable <= 1'b0;
      result.vector_enable <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            row_open <= 1'b0;
            state <= ST_COLLECT;
          end
        end
        ST_COLLECT: begin
          if (accept) begin
            row_open <= !elem_last;
            // Whole row in, start normalizing
            if (elem_last) begin
              state <= ST_DIVIDE_START;
            end
          end
        end
        ST_DIVIDE_START: begin
          state <= ST_DIVIDE_WAIT;
        end
        ST_DIVIDE_WAIT: begin
          if (div_done) begin
            result.data <= quotient;
            result.scalar_enable <= 1'b1;
            result.vector_enable <= elem_last;
            // Job end rides on the final quotient
            ready <= elem_last && row_last;
            state <= ST_EMIT;
          end
        end
        ST_EMIT: begin
          if (!elem_last) begin
            state <= ST_DIVIDE_START;
          end else if (row_last) begin
            state <= ST_IDLE;
          end else begin
            state <= ST_COLLECT;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/softmax_divider.sv
// Restoring sequential divider

`timescale 1ns/100ps
`default_nettype none

module softmax_divider (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire                            div_start,
  input  softmax_pkg::div_req_t          req,
  output logic                           div_done,
  output logic [softmax_pkg::DATA_W-1:0] quotient
);

  import softmax_pkg::*;

  // Control
  logic busy;
  logic [DIV_CNT_W-1:0] step_cnt;
  logic last_step;

  // Datapath, dividend bits shift out as quotient bits shift in
  logic [SUM_W-1:0] rem_q;
  logic [DIVIDEND_W-1:0] quo_q;
  logic [SUM_W-1:0] divisor_q;

  // One step
  logic [SUM_W:0] shifted;
  logic [SUM_W:0] diff;
  logic fits;
  logic [SUM_W-1:0] rem_next;
  logic [DIVIDEND_W-1:0] quo_next;

  //////////////////////////////////////////////////
  // Shift-subtract step
  //////////////////////////////////////////////////

  assign shifted = {rem_q, quo_q[DIVIDEND_W-1]};
  assign diff = shifted - {1'b0, divisor_q};
  assign fits = (shifted >= {1'b0, divisor_q});
  // Remainder stays below the divisor
  assign rem_next = fits ? diff[SUM_W-1:0] : shifted[SUM_W-1:0];
  assign quo_next = {quo_q[DIVIDEND_W-2:0], fits};

  assign last_step = (step_cnt == DIV_CNT_W'(DIVIDEND_W - 1));

  // Floor result, at most 4096
  assign quotient = quo_q[DATA_W-1:0];

  // 1 load cycle plus DIVIDEND_W steps
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
      step_cnt <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (div_start) begin
        busy <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        step_cnt <= step_cnt + DIV_CNT_W'(1);
        if (last_step) begin
          busy <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (div_start) begin
      rem_q <= '0;
      quo_q <= req.dividend;
      divisor_q <= req.divisor;
    end else if (busy) begin
      rem_q <= rem_next;
      quo_q <= quo_next;
    end
  end

endmodule

`default_nettype wire

//--- source/softmax_exp_sum.sv
// Power-of-two term and row sum

`timescale 1ns/100ps
`default_nettype none

module softmax_exp_sum (
  input  wire                           CLK,
  input  wire                           RST,
  input  wire  [softmax_pkg::X_W-1:0]   data_in,
  input  wire                           accumulate,
  input  wire                           clear_sum,
  output logic [softmax_pkg::TERM_W-1:0] term,
  output logic [softmax_pkg::SUM_W-1:0]  row_sum
);

  import softmax_pkg::*;

  //////////////////////////////////////////////////
  // Exponent decode
  //////////////////////////////////////////////////

  // One-hot term, bit x set for input x
  always_comb begin
    term = '0;
    for (int i = 0; i < TERM_W; i++) begin
      if (data_in == X_W'(i)) begin
        term[i] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Row sum
  //////////////////////////////////////////////////

  // Held through the divide phase, cleared per row
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_sum <= '0;
    end else if (clear_sum) begin
      row_sum <= '0;
    end else if (accumulate) begin
      // 16 x 2^15 still fits
      row_sum <= row_sum + SUM_W'(term);
    end
  end

endmodule

`default_nettype wire

//--- source/softmax_index_counter.sv
// Softmax element and row counters

`timescale 1ns/100ps
`default_nettype none

module softmax_index_counter (
  input  wire                          CLK,
  input  wire                          RST,
  input  softmax_pkg::softmax_cfg_t    cfg,
  input  wire                          counter_clear,
  input  wire                          elem_inc,
  input  wire                          row_inc,
  output logic [softmax_pkg::LEN_W-1:0] elem_index,
  output logic                         elem_last,
  output logic                         row_last
);

  import softmax_pkg::*;

  // Job shape held for the whole job
  softmax_cfg_t cfg_q;
  logic [SIZE_W-1:0] row_index;
  logic [LEN_W-1:0] length_m1;
  logic [SIZE_W-1:0] size_m1;

  assign length_m1 = cfg_q.length - LEN_W'(1);
  assign size_m1 = cfg_q.size - SIZE_W'(1);

  // Only compare point against the job shape
  assign elem_last = (elem_index == length_m1);
  assign row_last = (row_index == size_m1);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cfg_q <= '0;
      elem_index <= '0;
      row_index <= '0;
    end else if (counter_clear) begin
      cfg_q <= cfg;
      elem_index <= '0;
      row_index <= '0;
    end else begin
      // Wrap after the last element of the row
      if (elem_inc) begin
        elem_index <= elem_last ? '0 : elem_index + LEN_W'(1);
      end
      if (row_inc) begin
        row_index <= row_index + SIZE_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- source/softmax_pkg.sv
// Softmax shared definitions

`default_nettype none

package softmax_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // One input exponent
  localparam int X_W = 4;
  // Power-of-two term, up to 2^15
  localparam int TERM_W = 16;
  // Row geometry
  localparam int MAX_LENGTH = 16;
  localparam int LEN_W = 5;
  localparam int SIZE_W = 8;
  localparam int BUF_ADDR_W = $clog2(MAX_LENGTH);
  // 16 terms of at most 2^15
  localparam int SUM_W = 20;
  // Output fraction bits, 1.0 == 4096
  localparam int FRAC_W = 12;
  localparam int DIVIDEND_W = TERM_W + FRAC_W;
  localparam int DIV_CNT_W = $clog2(DIVIDEND_W);
  localparam int DATA_W = 16;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // Job shape, sampled at start
  typedef struct packed {
    logic [SIZE_W-1:0] size;
    logic [LEN_W-1:0]  length;
  } softmax_cfg_t;

  // Output group of the top level
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              scalar_enable;
    logic              vector_enable;
  } softmax_out_t;

  // One division request
  typedef struct packed {
    logic [DIVIDEND_W-1:0] dividend;
    logic [SUM_W-1:0]      divisor;
  } div_req_t;

endpackage

`default_nettype wire

//--- source/softmax_row_buffer.sv
// Softmax row term buffer

`timescale 1ns/100ps
`default_nettype none

module softmax_row_buffer (
  input  wire                            CLK,
  input  wire                            write_enable,
  input  wire  [softmax_pkg::LEN_W-1:0]  elem_index,
  input  wire  [softmax_pkg::TERM_W-1:0] term,
  output logic [softmax_pkg::TERM_W-1:0] read_term
);

  import softmax_pkg::*;

  // One row of terms for the second pass
  logic [TERM_W-1:0] mem [MAX_LENGTH];

  // Index never passes MAX_LENGTH-1
  logic [BUF_ADDR_W-1:0] addr;

  assign addr = elem_index[BUF_ADDR_W-1:0];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  // Filled during collect
  always_ff @(posedge CLK) begin
    if (write_enable) begin
      mem[addr] <= term;
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Asynchronous, same index as the divide loop
  assign read_term = mem[addr];

endmodule

`default_nettype wire

//--- source/softmax_top.sv
// Fixed-point softmax engine

`timescale 1ns/100ps
`default_nettype none

module softmax_top (
  input  wire                          CLK,
  input  wire                          RST,
  input  wire                          start,
  input  softmax_pkg::softmax_cfg_t    cfg,
  input  wire                          in_vector_enable,
  input  wire                          in_scalar_enable,
  input  wire  [softmax_pkg::X_W-1:0]  data_in,
  output logic                         ready,
  output softmax_pkg::softmax_out_t    result
);

  import softmax_pkg::*;

  //////////////////////////////////////////////////
  // Wires
  //////////////////////////////////////////////////

  // FSM to counter
  logic counter_clear;
  logic elem_inc;
  logic row_inc;
  logic [LEN_W-1:0] elem_index;
  logic elem_last;
  logic row_last;

  // FSM to sum and buffer
  logic accumulate;
  logic clear_sum;
  logic write_enable;
  logic [TERM_W-1:0] term;
  logic [SUM_W-1:0] row_sum;
  logic [TERM_W-1:0] read_term;

  // Divider
  div_req_t div_req;
  logic div_start;
  logic div_done;
  logic [DATA_W-1:0] quotient;

  // Term scaled by 2^FRAC_W over the held row sum
  assign div_req.dividend = {read_term, {FRAC_W{1'b0}}};
  assign div_req.divisor = row_sum;

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  softmax_ctrl_fsm u_ctrl (
    .CLK(CLK), .RST(RST), .start(start),
    .in_vector_enable(in_vector_enable), .in_scalar_enable(in_scalar_enable),
    .elem_last(elem_last), .row_last(row_last),
    .div_done(div_done), .quotient(quotient),
    .counter_clear(counter_clear), .elem_inc(elem_inc), .row_inc(row_inc),
    .accumulate(accumulate), .clear_sum(clear_sum),
    .write_enable(write_enable), .div_start(div_start),
    .ready(ready), .result(result)
  );

  softmax_index_counter u_counter (
    .CLK(CLK), .RST(RST), .cfg(cfg),
    .counter_clear(counter_clear), .elem_inc(elem_inc), .row_inc(row_inc),
    .elem_index(elem_index), .elem_last(elem_last), .row_last(row_last)
  );

  softmax_exp_sum u_exp_sum (
    .CLK(CLK), .RST(RST), .data_in(data_in),
    .accumulate(accumulate), .clear_sum(clear_sum),
    .term(term), .row_sum(row_sum)
  );

  softmax_row_buffer u_row_buffer (
    .CLK(CLK), .write_enable(write_enable), .elem_index(elem_index),
    .term(term), .read_term(read_term)
  );

  softmax_divider u_divider (
    .CLK(CLK), .RST(RST), .div_start(div_start), .req(div_req),
    .div_done(div_done), .quotient(quotient)
  );

endmodule

`default_nettype wire

//--- sources.f
source/softmax_pkg.sv
source/softmax_index_counter.sv
source/softmax_exp_sum.sv
source/softmax_row_buffer.sv
source/softmax_divider.sv
source/softmax_ctrl_fsm.sv
source/softmax_top.sv
sim/softmax_clock_gen.sv
sim/softmax_tb.sv
